//--- hdl/display_pkg.sv
`default_nettype none

package display_pkg;

    // serial driver chains, one data line each
    localparam int LINES = 30;

    // greyscale depth per pixel, shifted msb first
    localparam int GREY_BITS = 16;

    // one bit per chain, bit k belongs to chain k
    typedef logic [LINES-1:0] slice_t;

    // greyscale value of a single pixel
    typedef logic [GREY_BITS-1:0] grey_t;

    // index of the lit column
    typedef logic [7:0] column_t;

endpackage

`default_nettype wire

//--- hdl/driver_pkg.sv
`default_nettype none

package driver_pkg;

    // length of the driver configuration register
    localparam int CONF_BITS = 48;

    // lat held high over the trailing bits selects the config write
    localparam int CONF_LAT_BITS = 4;

    // configuration fields, msb first
    localparam logic [7:0]  CONF_ID       = 8'h96;
    localparam logic [4:0]  CONF_FUNCTION = 5'b01011;
    // brightness for red, green and blue groups
    localparam logic [20:0] CONF_BRIGHT   = {7'h7f, 7'h7f, 7'h7f};
    // max current range per group
    localparam logic [8:0]  CONF_MAX_CUR  = {3'd4, 3'd4, 3'd4};
    localparam logic [4:0]  CONF_RESERVED = 5'b00000;

    // same word is sent on every chain
    localparam logic [CONF_BITS-1:0] CONF_WORD = {
        CONF_ID, CONF_FUNCTION, CONF_BRIGHT, CONF_MAX_CUR, CONF_RESERVED
    };

endpackage

`default_nettype wire

//--- hdl/framebuffer_emulator.sv
`timescale 1ns/1ps
`default_nettype none

module framebuffer_emulator #(
    parameter int COLUMNS = 8
) (
    input  wire                  clock_33,
    input  wire                  nrst,
    input  wire                  button,
    input  wire                  full,
    output logic                 wr_en,
    output display_pkg::slice_t  wr_data
);
    import display_pkg::*;

    localparam int SW = $clog2(GREY_BITS);

    column_t       col_cnt;
    logic [SW-1:0] slice_cnt;
    logic [SW-1:0] bit_idx;
    // running offset, bumped by each button press
    grey_t         offset;
    // offset frozen for the column being written
    grey_t         col_offset;
    grey_t         col_base;
    logic          button_q;
    logic          active;

    assign wr_en = active && !full;

    // slice 0 carries the msb
    assign bit_idx  = SW'(GREY_BITS - 1) - slice_cnt;
    assign col_base = (grey_t'(col_cnt) << 5) + col_offset;

    always_comb begin
        grey_t grey;
        for (int k = 0; k < LINES; k++) begin
            grey = col_base + grey_t'(k);
            wr_data[k] = grey[bit_idx];
        end
    end

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            active     <= 1'b0;
            button_q   <= 1'b0;
            offset     <= '0;
            col_offset <= '0;
            col_cnt    <= '0;
            slice_cnt  <= '0;
        end else begin
            active   <= 1'b1;
            button_q <= button;
            if (button && !button_q) begin
                offset <= offset + 1'b1;
            end
            if (wr_en) begin
                if (slice_cnt == SW'(GREY_BITS - 1)) begin
                    // last slice written, next column picks up the offset
                    slice_cnt  <= '0;
                    col_offset <= offset;
                    if (col_cnt == column_t'(COLUMNS - 1)) begin
                        col_cnt <= '0;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end else begin
                    slice_cnt <= slice_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/slice_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module slice_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                  clock_33,
    input  wire                  nrst,
    input  wire                  wr_en,
    input  wire display_pkg::slice_t wr_data,
    input  wire                  rd_en,
    output display_pkg::slice_t  rd_data,
    output logic                 full,
    output logic                 empty
);
    import display_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    slice_t      mem [FIFO_DEPTH];
    // msb of each pointer is the wrap bit
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_write;
    logic        do_read;

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_33) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    // head word is always visible
    assign rd_data = mem[rd_ptr[AW-1:0]];

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // producer must respect full
    a_no_write_when_full : assert property (
        @(posedge clock_33) disable iff (!nrst) !(wr_en && full)
    ) else $error("slice_fifo: write while full");

    // consumer must respect empty
    a_no_read_when_empty : assert property (
        @(posedge clock_33) disable iff (!nrst) !(rd_en && empty)
    ) else $error("slice_fifo: read while empty");

endmodule

`default_nettype wire

//--- hdl/driver_controller.sv
`timescale 1ns/1ps
`default_nettype none

module driver_controller #(
    parameter int BLANKING_TIME = 72
) (
    input  wire                  clock_33,
    input  wire                  nrst,
    input  wire display_pkg::slice_t rd_data,
    input  wire                  empty,
    output logic                 rd_en,
    output logic                 sclk,
    output logic                 gclk,
    output logic                 lat,
    output display_pkg::slice_t  sin,
    output logic                 driver_ready,
    output logic                 column_ready
);
    import display_pkg::*;
    import driver_pkg::*;

    localparam int BIT_W  = $clog2(CONF_BITS + 1);
    localparam int GCLK_W = $clog2(BLANKING_TIME + 1);

    localparam logic [2:0] S_CONF  = 3'd0;
    localparam logic [2:0] S_SHIFT = 3'd1;
    localparam logic [2:0] S_LATCH = 3'd2;
    localparam logic [2:0] S_BLANK = 3'd3;
    localparam logic [2:0] S_NEXT  = 3'd4;

    logic [2:0]           state;
    logic [BIT_W-1:0]     bit_cnt;
    // 0 sets up data with sclk low, 1 raises sclk
    logic                 phase;
    logic [GCLK_W-1:0]    gclk_cnt;
    logic [CONF_BITS-1:0] conf_sr;

    // pop the head slice as it is put on sin
    assign rd_en = (state == S_SHIFT) && !phase && !empty;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state        <= S_CONF;
            bit_cnt      <= '0;
            phase        <= 1'b0;
            gclk_cnt     <= '0;
            conf_sr      <= CONF_WORD;
            sclk         <= 1'b0;
            gclk         <= 1'b0;
            lat          <= 1'b0;
            sin          <= '0;
            driver_ready <= 1'b0;
            column_ready <= 1'b0;
        end else begin
            column_ready <= 1'b0;
            case (state)
                S_CONF: begin
                    if (bit_cnt < BIT_W'(CONF_BITS)) begin
                        if (!phase) begin
                            sclk  <= 1'b0;
                            sin   <= {LINES{conf_sr[CONF_BITS-1]}};
                            // lat over the trailing bits makes it a config write
                            lat   <= (bit_cnt >= BIT_W'(CONF_BITS - CONF_LAT_BITS));
                            phase <= 1'b1;
                        end else begin
                            sclk    <= 1'b1;
                            conf_sr <= {conf_sr[CONF_BITS-2:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                            phase   <= 1'b0;
                        end
                    end else if (!phase) begin
                        // idle cycle before the drivers are ready
                        sclk  <= 1'b0;
                        lat   <= 1'b0;
                        sin   <= '0;
                        phase <= 1'b1;
                    end else begin
                        driver_ready <= 1'b1;
                        bit_cnt      <= '0;
                        phase        <= 1'b0;
                        state        <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    if (!phase) begin
                        sclk <= 1'b0;
                        // hold with sclk low until a slice is there
                        if (!empty) begin
                            sin   <= rd_data;
                            phase <= 1'b1;
                        end
                    end else begin
                        sclk  <= 1'b1;
                        phase <= 1'b0;
                        if (bit_cnt == BIT_W'(GREY_BITS - 1)) begin
                            bit_cnt <= '0;
                            state   <= S_LATCH;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                S_LATCH: begin
                    sclk  <= 1'b0;
                    lat   <= 1'b1;
                    state <= S_BLANK;
                end
                S_BLANK: begin
                    lat <= 1'b0;
                    if (!phase) begin
                        gclk  <= 1'b1;
                        phase <= 1'b1;
                    end else begin
                        gclk  <= 1'b0;
                        phase <= 1'b0;
                        if (gclk_cnt == GCLK_W'(BLANKING_TIME - 1)) begin
                            gclk_cnt <= '0;
                            state    <= S_NEXT;
                        end else begin
                            gclk_cnt <= gclk_cnt + 1'b1;
                        end
                    end
                end
                S_NEXT: begin
                    // column mux steps on this pulse
                    column_ready <= 1'b1;
                    state        <= S_SHIFT;
                end
                default: begin
                    state <= S_CONF;
                end
            endcase
        end
    end

    // data latch only between bits once configured
    a_lat_not_with_sclk : assert property (
        @(posedge clock_33) disable iff (!nrst) driver_ready |-> !(lat && sclk)
    ) else $error("driver_controller: lat high with sclk high");

    a_column_ready_pulse : assert property (
        @(posedge clock_33) disable iff (!nrst) column_ready |=> !column_ready
    ) else $error("driver_controller: column_ready longer than one cycle");

endmodule

`default_nettype wire

//--- hdl/column_mux.sv
`timescale 1ns/1ps
`default_nettype none

module column_mux #(
    parameter int COLUMNS = 8
) (
    input  wire                   clock_33,
    input  wire                   nrst,
    input  wire                   column_ready,
    output display_pkg::column_t  mux_out
);
    import display_pkg::*;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            mux_out <= '0;
        end else if (column_ready) begin
            // wrap back to the first column
            if (mux_out == column_t'(COLUMNS - 1)) begin
                mux_out <= '0;
            end else begin
                mux_out <= mux_out + 1'b1;
            end
        end
    end

    // selected column stays on the panel
    a_column_in_range : assert property (
        @(posedge clock_33) disable iff (!nrst) mux_out < COLUMNS
    ) else $error("column_mux: column index out of range");

endmodule

`default_nettype wire

//--- hdl/led_panel_top.sv
`timescale 1ns/1ps
`default_nettype none

module led_panel_top #(
    parameter int COLUMNS       = 8,
    parameter int FIFO_DEPTH    = 8,
    parameter int BLANKING_TIME = 72
) (
    input  wire                   clock_33,
    input  wire                   nrst,
    input  wire                   button,
    output logic                  sclk,
    output logic                  gclk,
    output logic                  lat,
    output display_pkg::slice_t   sin,
    output logic                  driver_ready,
    output logic                  column_ready,
    output display_pkg::column_t  mux_out
);
    import display_pkg::*;

    // producer to buffer
    logic   wr_en;
    slice_t wr_data;
    logic   full;

    // buffer to consumer
    logic   rd_en;
    slice_t rd_data;
    logic   empty;

    framebuffer_emulator #(.COLUMNS(COLUMNS)) u_framebuffer_emulator (
        .clock_33 (clock_33),
        .nrst     (nrst),
        .button   (button),
        .full     (full),
        .wr_en    (wr_en),
        .wr_data  (wr_data)
    );

    slice_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_slice_fifo (
        .clock_33 (clock_33),
        .nrst     (nrst),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .full     (full),
        .empty    (empty)
    );

    driver_controller #(.BLANKING_TIME(BLANKING_TIME)) u_driver_controller (
        .clock_33     (clock_33),
        .nrst         (nrst),
        .rd_data      (rd_data),
        .empty        (empty),
        .rd_en        (rd_en),
        .sclk         (sclk),
        .gclk         (gclk),
        .lat          (lat),
        .sin          (sin),
        .driver_ready (driver_ready),
        .column_ready (column_ready)
    );

    column_mux #(.COLUMNS(COLUMNS)) u_column_mux (
        .clock_33     (clock_33),
        .nrst         (nrst),
        .column_ready (column_ready),
        .mux_out      (mux_out)
    );

endmodule

`default_nettype wire

//--- sim/tb_led_panel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_led_panel;
    import display_pkg::*;
    import driver_pkg::*;

    localparam int COLUMNS       = 8;
    localparam int FIFO_DEPTH    = 8;
    localparam int BLANKING_TIME = 72;

    // columns read after the button press
    localparam int BUTTON_COLS   = FIFO_DEPTH / 16 + 4;
    localparam int COLUMN_CYCLES = 33 + 2 * BLANKING_TIME;
    localparam int TOTAL_CYCLES  = 6 + 97 + (2 * COLUMNS + BUTTON_COLS) * COLUMN_CYCLES;
    localparam int CYCLE_LIMIT   = 4 * TOTAL_CYCLES;

    logic     clock_33;
    logic     nrst;
    logic     button;
    logic     sclk;
    logic     gclk;
    logic     lat;
    slice_t   sin;
    logic     driver_ready;
    logic     column_ready;
    column_t  mux_out;

    int       error_count;
    int       cycle_count;
    int       press_ticks;
    int       exp_col;
    logic     prev_sclk;
    logic     prev_gclk;
    slice_t   got_slices [GREY_BITS];

    led_panel_top #(
        .COLUMNS       (COLUMNS),
        .FIFO_DEPTH    (FIFO_DEPTH),
        .BLANKING_TIME (BLANKING_TIME)
    ) dut (
        .clock_33     (clock_33),
        .nrst         (nrst),
        .button       (button),
        .sclk         (sclk),
        .gclk         (gclk),
        .lat          (lat),
        .sin          (sin),
        .driver_ready (driver_ready),
        .column_ready (column_ready),
        .mux_out      (mux_out)
    );

    initial begin
        clock_33 = 1'b0;
        forever #20 clock_33 = ~clock_33;
    end

    // hard stop if the DUT stalls
    always @(posedge clock_33) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("errors: %0d", error_count + 1);
            $display("Errors found");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("MISMATCH %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic protocol_error(input string what);
        error_count++;
        $display("protocol error at %0t: %s", $time, what);
    endtask

    // one clock with button driven at the edge and outputs sampled at the falling edge
    task automatic next_cycle();
        prev_sclk = sclk;
        prev_gclk = gclk;
        @(posedge clock_33);
        button <= (press_ticks > 0);
        if (press_ticks > 0) begin
            press_ticks--;
        end
        @(negedge clock_33);
    endtask

    // slice b holds bit 15-b of grey value 32*col + k + off
    function automatic slice_t pattern_slice(input int col, input int off, input int b);
        slice_t s;
        grey_t  grey;
        for (int k = 0; k < LINES; k++) begin
            grey = grey_t'(32 * col + k + off);
            s[k] = grey[GREY_BITS-1-b];
        end
        return s;
    endfunction

    function automatic logic column_matches(input int col, input int off);
        logic ok;
        ok = 1'b1;
        for (int b = 0; b < GREY_BITS; b++) begin
            if (got_slices[b] !== pattern_slice(col, off, b)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic expect_idle();
        compare_value("sclk", 32'h0, 32'(sclk));
        compare_value("gclk", 32'h0, 32'(gclk));
        compare_value("lat", 32'h0, 32'(lat));
        compare_value("column_ready", 32'h0, 32'(column_ready));
        compare_value("driver_ready", 32'h0, 32'(driver_ready));
        compare_value("wr_en", 32'h0, 32'(dut.wr_en));
        compare_value("rd_en", 32'h0, 32'(dut.rd_en));
        compare_value("sin", 32'h0, 32'(sin));
        compare_value("mux_out", 32'h0, 32'(mux_out));
    endtask

    task automatic reset_sequence();
        for (int i = 0; i < 5; i++) begin
            @(posedge clock_33);
            @(negedge clock_33);
            expect_idle();
        end
        @(posedge clock_33);
        nrst <= 1'b1;
        @(negedge clock_33);
        expect_idle();
    endtask

    task automatic configuration_phase();
        int n;
        n = 0;
        while (n < CONF_BITS) begin
            next_cycle();
            assert (!driver_ready) else protocol_error("driver_ready high during configuration");
            if (sclk && !prev_sclk) begin
                compare_value("sin", 32'({LINES{CONF_WORD[CONF_BITS-1-n]}}), 32'(sin));
                compare_value("lat", 32'(n >= CONF_BITS - CONF_LAT_BITS), 32'(lat));
                n++;
            end
        end
        while (lat) begin
            next_cycle();
        end
        assert (!driver_ready) else protocol_error("driver_ready rose before lat fell");
        next_cycle();
        assert (driver_ready) else protocol_error("driver_ready not high one cycle after lat");
    endtask

    // reads one displayed column and returns the matching offset or -1
    task automatic read_column(input int col, input int min_off, input int max_off,
                               output int seen_off);
        int   b;
        int   pulses;
        logic done;
        b = 0;
        pulses = 0;
        while (b < GREY_BITS) begin
            next_cycle();
            assert (driver_ready) else protocol_error("driver_ready dropped during column data");
            assert (!lat) else protocol_error("lat high during column data");
            if (sclk && !prev_sclk) begin
                got_slices[b] = sin;
                b++;
            end
        end
        seen_off = -1;
        for (int off = max_off; off >= min_off; off--) begin
            if (column_matches(col, off)) begin
                seen_off = off;
            end
        end
        assert (seen_off >= 0) else begin
            for (int i = 0; i < GREY_BITS; i++) begin
                compare_value("sin", 32'(pattern_slice(col, min_off, i)), 32'(got_slices[i]));
            end
        end
        // data latch right after the last bit
        next_cycle();
        assert (lat && !sclk) else protocol_error("no lat pulse with sclk low after data");
        done = 1'b0;
        while (!done) begin
            next_cycle();
            if (gclk && !prev_gclk) begin
                pulses++;
            end
            assert (!(sclk && !prev_sclk)) else protocol_error("sclk rise during blanking");
            assert (!lat) else protocol_error("lat high during blanking");
            done = column_ready;
        end
        compare_value("gclk pulse count", 32'(BLANKING_TIME), 32'(pulses));
        compare_value("mux_out", 32'(col), 32'(mux_out));
        next_cycle();
        assert (!column_ready) else protocol_error("column_ready longer than one cycle");
        compare_value("mux_out", 32'((col + 1) % COLUMNS), 32'(mux_out));
    endtask

    task automatic column_sequence();
        int off;
        for (int n = 0; n < 2 * COLUMNS; n++) begin
            read_column(exp_col, 0, 0, off);
            exp_col = (exp_col + 1) % COLUMNS;
        end
    endtask

    task automatic button_press();
        int off;
        int first_one;
        first_one = 0;
        press_ticks = 2;
        for (int n = 1; n <= BUTTON_COLS; n++) begin
            read_column(exp_col, 0, 1, off);
            assert (!(first_one != 0 && off == 0)) else
                protocol_error("column offset went back to 0 after offset 1");
            if (off == 1 && first_one == 0) begin
                first_one = n;
            end
            exp_col = (exp_col + 1) % COLUMNS;
        end
        assert (first_one != 0 && first_one <= FIFO_DEPTH / 16 + 2) else
            protocol_error("offset 1 did not reach the panel in time after the button press");
    endtask

    initial begin
        nrst        = 1'b0;
        button      = 1'b0;
        press_ticks = 0;
        error_count = 0;
        cycle_count = 0;
        exp_col     = 0;
        prev_sclk   = 1'b0;
        prev_gclk   = 1'b0;

        reset_sequence();
        configuration_phase();
        column_sequence();
        button_press();

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/display_pkg.sv
hdl/driver_pkg.sv
hdl/framebuffer_emulator.sv
hdl/slice_fifo.sv
hdl/driver_controller.sv
hdl/column_mux.sv
hdl/led_panel_top.sv
sim/tb_led_panel.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the LED panel testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_led_panel \
    -f sources.f \
    -o tb_led_panel

./obj_dir/tb_led_panel > sim.log 2>&1

cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
